// ==== source/mips_isa_pkg.sv ====
// MIPS back end ISA package: operation enum, opcode and immediate widths

package mips_isa_pkg;

	// ======================================================================
	// instruction field widths
	// ======================================================================
	// opcode width after decode
	localparam int OP_W = 4;
	// immediate field of I-type instructions
	localparam int IMM_W = 16;

	// ======================================================================
	// decoded operations
	// ======================================================================
	typedef enum logic [OP_W-1:0] {
		OP_NOP  = 4'd0,
		// register to register
		OP_ADD  = 4'd1,
		OP_SUB  = 4'd2,
		OP_AND  = 4'd3,
		OP_OR   = 4'd4,
		OP_SLT  = 4'd5,
		// immediate and memory
		OP_ADDI = 4'd6,
		OP_LW   = 4'd7,
		OP_SW   = 4'd8,
		// control flow
		OP_BEQ  = 4'd9,
		OP_JR   = 4'd10
	} e_op;

endpackage

// ==== source/mips_pipe_pkg.sv ====
// MIPS back end pipeline package: width constants and forwarding-select enum

package mips_pipe_pkg;

	// ======================================================================
	// datapath widths
	// ======================================================================
	// register index
	localparam int REG_AW = 5;
	// data and address
	localparam int DATA_W = 32;
	// registers in the file
	localparam int NUM_REGS = 1 << REG_AW;

	// ======================================================================
	// operand source for execute
	// ======================================================================
	typedef enum logic [1:0] {
		// value read from the register file
		FWD_REG = 2'd0,
		// result of the instruction in the memory stage
		FWD_MEM = 2'd1,
		// value held in the writeback register
		FWD_WB  = 2'd2
	} e_fwd;

endpackage

// ==== source/data_ram.sv ====
// data RAM: word addressed, combinational read, write on rising edge

`timescale 1ns/100ps

module data_ram
	import mips_pipe_pkg::*;
#(
	parameter int RAM_DEPTH = 64
)
(
	input  logic                         i_clk,
	input  logic [$clog2(RAM_DEPTH)-1:0] i_addr,
	input  logic                         i_we,
	input  logic [DATA_W-1:0]            i_wdata,
	output logic [DATA_W-1:0]            o_rdata
);

	// word storage, contents undefined after reset
	logic [DATA_W-1:0] mem [RAM_DEPTH];

	// single write port
	always_ff @(posedge i_clk)
	begin
		if (i_we)
			mem[i_addr] <= i_wdata;
	end

	// read in the same cycle as the address
	assign o_rdata = mem[i_addr];

endmodule

// ==== source/reg_file.sv ====
// register file: 32 x 32 bit, two combinational reads, one synchronous write

`timescale 1ns/100ps

module reg_file
	import mips_pipe_pkg::*;
(
	input  logic              i_clk,
	input  logic              i_reset,
	input  logic [REG_AW-1:0] i_rs_addr,
	input  logic [REG_AW-1:0] i_rt_addr,
	output logic [DATA_W-1:0] o_rs_data,
	output logic [DATA_W-1:0] o_rt_data,
	input  logic              i_we,
	input  logic [REG_AW-1:0] i_waddr,
	input  logic [DATA_W-1:0] i_wdata
);

	// storage
	logic [DATA_W-1:0] regs [NUM_REGS];

	// write port, whole file cleared on reset
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			for (int i = 0; i < NUM_REGS; i++)
				regs[i] <= '0;
		end
		else if (i_we && (i_waddr != '0))
		begin
			regs[i_waddr] <= i_wdata;
		end
	end

	// reads, register zero pinned to 0
	assign o_rs_data = (i_rs_addr == '0) ? '0 : regs[i_rs_addr];
	assign o_rt_data = (i_rt_addr == '0) ? '0 : regs[i_rt_addr];

	// execute clears regwrite for destination zero two cycles before this port
	a_no_write_r0: assert property (@(posedge i_clk) disable iff (i_reset)
		i_we |-> (i_waddr != '0));

endmodule

// ==== source/ex_stage.sv ====
// execute stage: decode, operand forwarding, ALU, branch target, EX/MEM register

`timescale 1ns/100ps

module ex_stage
	import mips_isa_pkg::*;
	import mips_pipe_pkg::*;
(
	input  logic              i_clk,
	input  logic              i_reset,
	// issue
	input  logic              i_valid,
	input  e_op               i_op,
	input  logic [REG_AW-1:0] i_rs,
	input  logic [REG_AW-1:0] i_rt,
	input  logic [REG_AW-1:0] i_rd,
	input  logic [IMM_W-1:0]  i_imm,
	input  logic [DATA_W-1:0] i_pc_next,
	// register file read data
	input  logic [DATA_W-1:0] i_rs_data,
	input  logic [DATA_W-1:0] i_rt_data,
	// forwarding from memory stage and writeback register
	input  logic              i_mem_fwd_we,
	input  logic [REG_AW-1:0] i_mem_fwd_addr,
	input  logic [DATA_W-1:0] i_mem_fwd_data,
	input  logic              i_wb_fwd_we,
	input  logic [REG_AW-1:0] i_wb_fwd_addr,
	input  logic [DATA_W-1:0] i_wb_fwd_data,
	// EX/MEM register
	output logic              o_ex_valid,
	output logic              o_ex_memtoreg,
	output logic              o_ex_regwrite,
	output logic              o_ex_memwrite,
	output logic              o_ex_branch,
	output logic              o_ex_jumpreg,
	output logic              o_ex_zero,
	output logic [DATA_W-1:0] o_ex_alu,
	output logic [DATA_W-1:0] o_ex_store,
	output logic [DATA_W-1:0] o_ex_target,
	output logic [DATA_W-1:0] o_ex_rs,
	output logic [REG_AW-1:0] o_ex_dest
);

	e_fwd              rs_sel;
	e_fwd              rt_sel;
	logic [DATA_W-1:0] rs_val;
	logic [DATA_W-1:0] rt_val;
	logic [DATA_W-1:0] imm_ext;
	logic [DATA_W-1:0] op_b;
	logic [DATA_W-1:0] alu_res;
	logic [REG_AW-1:0] dest;
	logic              use_imm;
	logic              wr_rd;
	logic              wr_rt;
	logic              memtoreg;
	logic              memwrite;
	logic              branch;
	logic              jumpreg;
	logic              regwrite;

	// ======================================================================
	// forwarding
	// ======================================================================
	// youngest producer wins, register zero never forwarded
	function automatic e_fwd pick_src(input logic [REG_AW-1:0] addr);
		e_fwd sel;
		sel = FWD_REG;
		if (addr != '0)
		begin
			if (i_mem_fwd_we && (i_mem_fwd_addr == addr))
				sel = FWD_MEM;
			else if (i_wb_fwd_we && (i_wb_fwd_addr == addr))
				sel = FWD_WB;
		end
		return sel;
	endfunction

	function automatic logic [DATA_W-1:0] fwd_value(input e_fwd sel,
		input logic [DATA_W-1:0] reg_data);
		logic [DATA_W-1:0] val;
		case (sel)
			FWD_MEM: val = i_mem_fwd_data;
			FWD_WB:  val = i_wb_fwd_data;
			default: val = reg_data;
		endcase
		return val;
	endfunction

	always_comb
	begin
		rs_sel = pick_src(i_rs);
		rt_sel = pick_src(i_rt);
		rs_val = fwd_value(rs_sel, i_rs_data);
		rt_val = fwd_value(rt_sel, i_rt_data);
	end

	// ======================================================================
	// decode
	// ======================================================================
	always_comb
	begin
		memtoreg = 1'b0;
		memwrite = 1'b0;
		branch   = 1'b0;
		jumpreg  = 1'b0;
		wr_rd    = 1'b0;
		wr_rt    = 1'b0;
		use_imm  = 1'b0;
		case (i_op)
			OP_ADD, OP_SUB, OP_AND, OP_OR, OP_SLT:
				wr_rd = 1'b1;
			OP_ADDI:
			begin
				wr_rt   = 1'b1;
				use_imm = 1'b1;
			end
			OP_LW:
			begin
				wr_rt    = 1'b1;
				use_imm  = 1'b1;
				memtoreg = 1'b1;
			end
			OP_SW:
			begin
				use_imm  = 1'b1;
				memwrite = 1'b1;
			end
			OP_BEQ:
				branch = 1'b1;
			OP_JR:
				jumpreg = 1'b1;
			default: ;
		endcase
	end

	// rt for I-type writers, rd otherwise
	assign dest     = wr_rt ? i_rt : i_rd;
	assign regwrite = (wr_rd || wr_rt) && (dest != '0);

	// ======================================================================
	// ALU and branch target
	// ======================================================================
	assign imm_ext = {{(DATA_W-IMM_W){i_imm[IMM_W-1]}}, i_imm};
	assign op_b    = use_imm ? imm_ext : rt_val;

	always_comb
	begin
		case (i_op)
			// beq compares by subtraction
			OP_SUB, OP_BEQ: alu_res = rs_val - op_b;
			OP_AND:         alu_res = rs_val & op_b;
			OP_OR:          alu_res = rs_val | op_b;
			OP_SLT:         alu_res = {{(DATA_W-1){1'b0}}, $signed(rs_val) < $signed(op_b)};
			// add, addi and address generation
			default:        alu_res = rs_val + op_b;
		endcase
	end

	// ======================================================================
	// EX/MEM register
	// ======================================================================
	// control bits, qualified by issue valid
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			o_ex_valid    <= 1'b0;
			o_ex_memtoreg <= 1'b0;
			o_ex_regwrite <= 1'b0;
			o_ex_memwrite <= 1'b0;
			o_ex_branch   <= 1'b0;
			o_ex_jumpreg  <= 1'b0;
		end
		else
		begin
			o_ex_valid    <= i_valid;
			o_ex_memtoreg <= i_valid & memtoreg;
			o_ex_regwrite <= i_valid & regwrite;
			o_ex_memwrite <= i_valid & memwrite;
			o_ex_branch   <= i_valid & branch;
			o_ex_jumpreg  <= i_valid & jumpreg;
		end
	end

	// payload
	always_ff @(posedge i_clk)
	begin
		o_ex_zero   <= (alu_res == '0);
		o_ex_alu    <= alu_res;
		o_ex_store  <= rt_val;
		o_ex_target <= i_pc_next + (imm_ext << 2);
		o_ex_rs     <= rs_val;
		o_ex_dest   <= dest;
	end

	// front end must never issue an undecoded op
	a_op_known: assert property (@(posedge i_clk) disable iff (i_reset)
		i_valid |-> !$isunknown(i_op));

endmodule

// ==== source/mem_stage.sv ====
// memory stage: PC source, jump register select, data access, MEM/WB register

`timescale 1ns/100ps

module mem_stage
	import mips_pipe_pkg::*;
#(
	parameter int RAM_DEPTH = 64
)
(
	input  logic              i_clk,
	input  logic              i_reset,
	// EX/MEM register
	input  logic              i_ex_valid,
	input  logic              i_ex_memtoreg,
	input  logic              i_ex_regwrite,
	input  logic              i_ex_memwrite,
	input  logic              i_ex_branch,
	input  logic              i_ex_jumpreg,
	input  logic              i_ex_zero,
	input  logic [DATA_W-1:0] i_ex_alu,
	input  logic [DATA_W-1:0] i_ex_store,
	input  logic [DATA_W-1:0] i_ex_target,
	input  logic [DATA_W-1:0] i_ex_rs,
	input  logic [REG_AW-1:0] i_ex_dest,
	// redirect to the front end
	output logic              o_pc_redirect,
	output logic [DATA_W-1:0] o_pc_target,
	// forwarding of this stage's result
	output logic              o_mem_fwd_we,
	output logic [REG_AW-1:0] o_mem_fwd_addr,
	output logic [DATA_W-1:0] o_mem_fwd_data,
	// writeback register
	output logic              o_wb_we,
	output logic [REG_AW-1:0] o_wb_addr,
	output logic [DATA_W-1:0] o_wb_data
);

	localparam int RAM_AW = $clog2(RAM_DEPTH);

	logic [RAM_AW-1:0] ram_addr;
	logic [DATA_W-1:0] ram_rdata;
	logic              ram_we;
	logic [DATA_W-1:0] mem_result;

	// ======================================================================
	// PC source
	// ======================================================================
	// taken beq or any jr
	assign o_pc_redirect = i_ex_valid & ((i_ex_branch & i_ex_zero) | i_ex_jumpreg);
	// jump register select
	assign o_pc_target   = i_ex_jumpreg ? i_ex_rs : i_ex_target;

	// ======================================================================
	// data access
	// ======================================================================
	// byte address to word index, wrapped to depth
	assign ram_addr = RAM_AW'((i_ex_alu >> 2) % RAM_DEPTH);
	assign ram_we   = i_ex_valid & i_ex_memwrite;

	data_ram #(
		.RAM_DEPTH (RAM_DEPTH)
	) data_ram_i (
		.i_clk   (i_clk),
		.i_addr  (ram_addr),
		.i_we    (ram_we),
		.i_wdata (i_ex_store),
		.o_rdata (ram_rdata)
	);

	// load data or ALU result
	assign mem_result = i_ex_memtoreg ? ram_rdata : i_ex_alu;

	assign o_mem_fwd_we   = i_ex_valid & i_ex_regwrite;
	assign o_mem_fwd_addr = i_ex_dest;
	assign o_mem_fwd_data = mem_result;

	// ======================================================================
	// MEM/WB register
	// ======================================================================
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			o_wb_we <= 1'b0;
		else
			o_wb_we <= i_ex_valid & i_ex_regwrite;
	end

	always_ff @(posedge i_clk)
	begin
		o_wb_addr <= i_ex_dest;
		o_wb_data <= mem_result;
	end

	// decode sets at most one control-flow bit per instruction
	a_one_flow: assert property (@(posedge i_clk) disable iff (i_reset)
		i_ex_valid |-> !(i_ex_branch && i_ex_jumpreg));

endmodule

// ==== source/mips_backend.sv ====
// MIPS back end top: register file, execute stage and memory stage

`timescale 1ns/100ps

module mips_backend
	import mips_isa_pkg::*;
	import mips_pipe_pkg::*;
#(
	parameter int RAM_DEPTH = 64
)
(
	input  logic              i_clk,
	input  logic              i_reset,
	// decoded instruction from the front end
	input  logic              i_valid,
	input  e_op               i_op,
	input  logic [REG_AW-1:0] i_rs,
	input  logic [REG_AW-1:0] i_rt,
	input  logic [REG_AW-1:0] i_rd,
	input  logic [IMM_W-1:0]  i_imm,
	input  logic [DATA_W-1:0] i_pc_next,
	// redirect
	output logic              o_pc_redirect,
	output logic [DATA_W-1:0] o_pc_target,
	// writeback
	output logic              o_wb_we,
	output logic [REG_AW-1:0] o_wb_addr,
	output logic [DATA_W-1:0] o_wb_data
);

	// ======================================================================
	// interconnect
	// ======================================================================
	// register file reads
	logic [DATA_W-1:0] rs_data;
	logic [DATA_W-1:0] rt_data;
	// EX/MEM register
	logic              ex_valid;
	logic              ex_memtoreg;
	logic              ex_regwrite;
	logic              ex_memwrite;
	logic              ex_branch;
	logic              ex_jumpreg;
	logic              ex_zero;
	logic [DATA_W-1:0] ex_alu;
	logic [DATA_W-1:0] ex_store;
	logic [DATA_W-1:0] ex_target;
	logic [DATA_W-1:0] ex_rs;
	logic [REG_AW-1:0] ex_dest;
	// memory stage forwarding
	logic              mem_fwd_we;
	logic [REG_AW-1:0] mem_fwd_addr;
	logic [DATA_W-1:0] mem_fwd_data;

	// ======================================================================
	// instances
	// ======================================================================
	// write port fed from the writeback register
	reg_file reg_file_i (
		.i_clk     (i_clk),
		.i_reset   (i_reset),
		.i_rs_addr (i_rs),
		.i_rt_addr (i_rt),
		.o_rs_data (rs_data),
		.o_rt_data (rt_data),
		.i_we      (o_wb_we),
		.i_waddr   (o_wb_addr),
		.i_wdata   (o_wb_data)
	);

	ex_stage ex_stage_i (
		.i_clk          (i_clk),
		.i_reset        (i_reset),
		.i_valid        (i_valid),
		.i_op           (i_op),
		.i_rs           (i_rs),
		.i_rt           (i_rt),
		.i_rd           (i_rd),
		.i_imm          (i_imm),
		.i_pc_next      (i_pc_next),
		.i_rs_data      (rs_data),
		.i_rt_data      (rt_data),
		.i_mem_fwd_we   (mem_fwd_we),
		.i_mem_fwd_addr (mem_fwd_addr),
		.i_mem_fwd_data (mem_fwd_data),
		// writeback register doubles as the second forwarding source
		.i_wb_fwd_we    (o_wb_we),
		.i_wb_fwd_addr  (o_wb_addr),
		.i_wb_fwd_data  (o_wb_data),
		.o_ex_valid     (ex_valid),
		.o_ex_memtoreg  (ex_memtoreg),
		.o_ex_regwrite  (ex_regwrite),
		.o_ex_memwrite  (ex_memwrite),
		.o_ex_branch    (ex_branch),
		.o_ex_jumpreg   (ex_jumpreg),
		.o_ex_zero      (ex_zero),
		.o_ex_alu       (ex_alu),
		.o_ex_store     (ex_store),
		.o_ex_target    (ex_target),
		.o_ex_rs        (ex_rs),
		.o_ex_dest      (ex_dest)
	);

	mem_stage #(
		.RAM_DEPTH (RAM_DEPTH)
	) mem_stage_i (
		.i_clk          (i_clk),
		.i_reset        (i_reset),
		.i_ex_valid     (ex_valid),
		.i_ex_memtoreg  (ex_memtoreg),
		.i_ex_regwrite  (ex_regwrite),
		.i_ex_memwrite  (ex_memwrite),
		.i_ex_branch    (ex_branch),
		.i_ex_jumpreg   (ex_jumpreg),
		.i_ex_zero      (ex_zero),
		.i_ex_alu       (ex_alu),
		.i_ex_store     (ex_store),
		.i_ex_target    (ex_target),
		.i_ex_rs        (ex_rs),
		.i_ex_dest      (ex_dest),
		.o_pc_redirect  (o_pc_redirect),
		.o_pc_target    (o_pc_target),
		.o_mem_fwd_we   (mem_fwd_we),
		.o_mem_fwd_addr (mem_fwd_addr),
		.o_mem_fwd_data (mem_fwd_data),
		.o_wb_we        (o_wb_we),
		.o_wb_addr      (o_wb_addr),
		.o_wb_data      (o_wb_data)
	);

endmodule

// ==== bench/tb_mips_backend.sv ====
// testbench for the MIPS back end: clock, reset, random stimulus, reference model, checks

`timescale 1ns/100ps

module tb_mips_backend
	import mips_isa_pkg::*;
	import mips_pipe_pkg::*;
();

	localparam int RAM_DEPTH     = 64;
	localparam int RESET_TIMEOUT = 10;
	localparam int DRAIN_TIMEOUT = 8;
	localparam int RUN_LIMIT_NS  = 100000;

	logic              i_clk;
	logic              i_reset;
	logic              i_valid;
	e_op               i_op;
	logic [REG_AW-1:0] i_rs;
	logic [REG_AW-1:0] i_rt;
	logic [REG_AW-1:0] i_rd;
	logic [IMM_W-1:0]  i_imm;
	logic [DATA_W-1:0] i_pc_next;
	logic              o_pc_redirect;
	logic [DATA_W-1:0] o_pc_target;
	logic              o_wb_we;
	logic [REG_AW-1:0] o_wb_addr;
	logic [DATA_W-1:0] o_wb_data;

	// reference state, both start at zero
	logic [DATA_W-1:0] m_regs [32];
	logic [DATA_W-1:0] m_mem [RAM_DEPTH];

	// expected outputs in flight, oldest at the front
	logic              q_wb_we [$];
	logic [REG_AW-1:0] q_wb_addr [$];
	logic [DATA_W-1:0] q_wb_data [$];
	logic              q_redir [$];
	logic [DATA_W-1:0] q_target [$];

	int errors;
	int checks;
	int tests;
	int test_base;
	int n;
	logic [IMM_W-1:0] v;
	logic [REG_AW-1:0] r;

	mips_backend #(
		.RAM_DEPTH (RAM_DEPTH)
	) dut_i (
		.i_clk         (i_clk),
		.i_reset       (i_reset),
		.i_valid       (i_valid),
		.i_op          (i_op),
		.i_rs          (i_rs),
		.i_rt          (i_rt),
		.i_rd          (i_rd),
		.i_imm         (i_imm),
		.i_pc_next     (i_pc_next),
		.o_pc_redirect (o_pc_redirect),
		.o_pc_target   (o_pc_target),
		.o_wb_we       (o_wb_we),
		.o_wb_addr     (o_wb_addr),
		.o_wb_data     (o_wb_data)
	);

	// ======================================================================
	// clock and watchdog
	// ======================================================================
	initial
	begin
		i_clk = 1'b0;
		forever #4 i_clk = ~i_clk;
	end

	initial
	begin
		#(RUN_LIMIT_NS);
		$display("timeout: simulation ran past %0d ns without finishing", RUN_LIMIT_NS);
		$display("Done: errors found");
		$finish;
	end

	// ======================================================================
	// helpers
	// ======================================================================
	task automatic flag_mismatch(input string msg);
		$display("MISMATCH at %0t: %s", $time, msg);
		errors++;
	endtask

	// idle entries for the cycles right after reset
	task automatic clear_expect();
		q_wb_we = '{1'b0, 1'b0};
		q_wb_addr = '{'0, '0};
		q_wb_data = '{'0, '0};
		q_redir = '{1'b0};
		q_target = '{'0};
	endtask

	function automatic logic pending();
		logic p;
		p = 1'b0;
		foreach (q_wb_we[k])
			p = p | q_wb_we[k];
		foreach (q_redir[k])
			p = p | q_redir[k];
		return p;
	endfunction

	function automatic logic [REG_AW-1:0] pick_reg(input int lo);
		return REG_AW'($urandom_range(7, lo));
	endfunction

	// word aligned
	function automatic logic [DATA_W-1:0] pick_pc();
		return DATA_W'($urandom()) & ~DATA_W'(3);
	endfunction

	// one instruction per cycle, model runs it in program order
	task automatic issue(input logic valid, input e_op op, input logic [REG_AW-1:0] rs,
		input logic [REG_AW-1:0] rt, input logic [REG_AW-1:0] rd,
		input logic [IMM_W-1:0] imm, input logic [DATA_W-1:0] pc_next);
		logic [DATA_W-1:0] a;
		logic [DATA_W-1:0] b;
		logic [DATA_W-1:0] simm;
		logic [DATA_W-1:0] res;
		logic [REG_AW-1:0] dest;
		logic              wr;
		logic              redir;
		logic [DATA_W-1:0] target;
		logic              exp_we;
		logic [REG_AW-1:0] exp_addr;
		logic [DATA_W-1:0] exp_data;
		logic              exp_redir;
		logic [DATA_W-1:0] exp_target;
		int                word;
		@(posedge i_clk);
		#1;
		i_valid = valid;
		i_op = op;
		i_rs = rs;
		i_rt = rt;
		i_rd = rd;
		i_imm = imm;
		i_pc_next = pc_next;
		a = m_regs[rs];
		b = m_regs[rt];
		simm = DATA_W'($signed(imm));
		word = int'(((a + simm) / 4) % RAM_DEPTH);
		wr = 1'b0;
		dest = rd;
		res = '0;
		redir = 1'b0;
		target = '0;
		if (valid)
		begin
			case (op)
				OP_ADD:  res = a + b;
				OP_SUB:  res = a - b;
				OP_AND:  res = a & b;
				OP_OR:   res = a | b;
				OP_SLT:  res = ($signed(a) < $signed(b)) ? 1 : 0;
				OP_ADDI: res = a + simm;
				OP_LW:   res = m_mem[word];
				OP_SW:   m_mem[word] = b;
				// branch target counts words past PC+4
				OP_BEQ:
				begin
					redir = (a == b);
					target = pc_next + simm * 4;
				end
				OP_JR:
				begin
					redir = 1'b1;
					target = a;
				end
				default: ;
			endcase
			// all but nop, store and control flow write a register
			wr = (op != OP_NOP) && (op != OP_SW) && (op != OP_BEQ) && (op != OP_JR);
			// I-type writers target rt
			if ((op == OP_ADDI) || (op == OP_LW))
				dest = rt;
		end
		// register zero is never written
		if (dest == '0)
			wr = 1'b0;
		if (wr)
			m_regs[dest] = res;
		q_wb_we.push_back(wr);
		q_wb_addr.push_back(dest);
		q_wb_data.push_back(res);
		q_redir.push_back(redir);
		q_target.push_back(target);
		// writeback from two issues back, redirect from one
		exp_we = q_wb_we.pop_front();
		exp_addr = q_wb_addr.pop_front();
		exp_data = q_wb_data.pop_front();
		exp_redir = q_redir.pop_front();
		exp_target = q_target.pop_front();
		@(negedge i_clk);
		checks++;
		if (o_wb_we !== exp_we)
			flag_mismatch($sformatf("o_wb_we %b, expected %b", o_wb_we, exp_we));
		else if (exp_we && ((o_wb_addr !== exp_addr) || (o_wb_data !== exp_data)))
			flag_mismatch($sformatf("writeback r%0d=%h, expected r%0d=%h",
				o_wb_addr, o_wb_data, exp_addr, exp_data));
		if (o_pc_redirect !== exp_redir)
			flag_mismatch($sformatf("o_pc_redirect %b, expected %b", o_pc_redirect, exp_redir));
		else if (exp_redir && (o_pc_target !== exp_target))
			flag_mismatch($sformatf("o_pc_target %h, expected %h", o_pc_target, exp_target));
	endtask

	task automatic drain();
		int k;
		k = 0;
		while (pending() && (k < DRAIN_TIMEOUT))
		begin
			issue(1'b1, OP_NOP, '0, '0, '0, '0, '0);
			k++;
		end
		if (pending())
		begin
			$display("pipeline still busy after %0d drain cycles", DRAIN_TIMEOUT);
			errors++;
		end
	endtask

	task automatic end_test(input string name);
		drain();
		tests++;
		if (errors == test_base)
			$display("test %0d %s: pass", tests, name);
		else
			$display("test %0d %s: FAIL with %0d errors", tests, name, errors - test_base);
		test_base = errors;
	endtask

	// ======================================================================
	// main sequence
	// ======================================================================
	initial
	begin
		void'($urandom(32'hc74be418));
		errors = 0;
		checks = 0;
		tests = 0;
		test_base = 0;
		i_reset = 1'b1;
		i_valid = 1'b0;
		i_op = OP_NOP;
		i_rs = '0;
		i_rt = '0;
		i_rd = '0;
		i_imm = '0;
		i_pc_next = '0;
		foreach (m_regs[k])
			m_regs[k] = '0;
		foreach (m_mem[k])
			m_mem[k] = '0;
		clear_expect();
		repeat (4) @(posedge i_clk);
		#1 i_reset = 1'b0;
		// outputs must settle low once reset is released
		n = 0;
		while (((o_wb_we !== 1'b0) || (o_pc_redirect !== 1'b0)) && (n < RESET_TIMEOUT))
		begin
			@(posedge i_clk);
			#1;
			n++;
		end
		if ((o_wb_we !== 1'b0) || (o_pc_redirect !== 1'b0))
		begin
			$display("outputs not low within %0d cycles after reset", RESET_TIMEOUT);
			$display("Done: errors found");
			$finish;
		end

		repeat (10)
			issue(1'b1, OP_NOP, pick_reg(0), pick_reg(0), pick_reg(0), IMM_W'($urandom()),
				pick_pc());
		end_test("idle after reset");

		// RAM has no reset, zero it to match the model
		for (int i = 0; i < RAM_DEPTH; i++)
			issue(1'b1, OP_SW, '0, '0, '0, IMM_W'(i * 4), '0);
		drain();

		// ADD..ADDI are encodings 1 to 6
		repeat (200)
			issue(1'b1, e_op'(4'($urandom_range(6, 1))), pick_reg(1), pick_reg(1),
				pick_reg(1), IMM_W'($urandom()), pick_pc());
		end_test("dependent ALU chains");

		repeat (40)
		begin
			issue(1'b1, OP_SW, '0, pick_reg(1), '0, IMM_W'($urandom_range(255, 0) * 4), '0);
			r = pick_reg(1);
			issue(1'b1, OP_LW, '0, r, '0, IMM_W'($urandom_range(255, 0) * 4), '0);
			issue(1'b1, OP_ADD, r, pick_reg(1), pick_reg(1), '0, '0);
		end
		end_test("loads and stores");

		repeat (20)
		begin
			v = IMM_W'($urandom());
			issue(1'b1, OP_ADDI, '0, 5'd1, '0, v, '0);
			issue(1'b1, OP_ADDI, '0, 5'd2, '0, v, '0);
			issue(1'b1, OP_BEQ, 5'd1, 5'd2, '0, IMM_W'($urandom()), pick_pc());
			issue(1'b1, OP_ADDI, '0, 5'd3, '0, v ^ IMM_W'($urandom_range(255, 1)), '0);
			issue(1'b1, OP_BEQ, 5'd1, 5'd3, '0, IMM_W'($urandom()), pick_pc());
		end
		end_test("branch equal");

		repeat (10)
		begin
			r = pick_reg(1);
			issue(1'b1, OP_ADDI, '0, r, '0, IMM_W'($urandom()), '0);
			issue(1'b1, OP_JR, r, '0, '0, '0, pick_pc());
			// writes aimed at register zero
			issue(1'b1, OP_ADD, pick_reg(1), pick_reg(1), '0, '0, '0);
			issue(1'b1, OP_ADDI, pick_reg(1), '0, '0, IMM_W'($urandom()), '0);
			issue(1'b1, OP_LW, '0, '0, '0, IMM_W'($urandom_range(63, 0) * 4), '0);
			issue(1'b1, OP_ADD, '0, '0, 5'd5, '0, '0);
			issue(1'b1, OP_JR, '0, '0, '0, '0, pick_pc());
		end
		end_test("jump register and r0");

		repeat (2000)
			issue($urandom_range(7, 0) != 0, e_op'(4'($urandom_range(10, 0))), pick_reg(0),
				pick_reg(0), pick_reg(0), IMM_W'($urandom()), pick_pc());
		end_test("random mix");

		$display("tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
		if (errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

// ==== sources.f ====
source/mips_isa_pkg.sv
source/mips_pipe_pkg.sv
source/data_ram.sv
source/reg_file.sv
source/ex_stage.sv
source/mem_stage.sv
source/mips_backend.sv
bench/tb_mips_backend.sv
